//--- lsu_cases.txt
# op (0 load, 1 store)  funct3  address  store_data  expected_load  fault, all hex
# expected_load is ignored for stores and for misaligned accesses
1 2 00000010 deadbeef 00000000 0
0 2 00000010 00000000 deadbeef 0
1 0 00000020 cafe0011 00000000 0
1 0 00000021 cafe0022 00000000 0
1 0 00000022 cafe0033 00000000 0
1 0 00000023 cafe0084 00000000 0
0 2 00000020 00000000 84332211 0
0 0 00000023 00000000 ffffff84 0
0 4 00000023 00000000 00000084 0
0 1 00000022 00000000 ffff8433 0
0 5 00000022 00000000 00008433 0
1 1 00000021 00005555 00000000 1
0 2 00000020 00000000 84332211 0
0 2 00000012 00000000 00000000 1
0 2 00000400 00000000 00000000 1
1 2 00000400 12345678 00000000 1
1 1 00000030 1234abcd 00000000 0
1 1 00000032 00005678 00000000 0
0 2 00000030 00000000 5678abcd 0
0 1 00000030 00000000 ffffabcd 0
0 4 00000031 00000000 000000ab 0
0 0 00000033 00000000 00000056 0
1 2 000003fc 0badf00d 00000000 0
0 2 000003fc 00000000 0badf00d 0

//--- lsu_uncached.f
lsu_pkg.sv
axil_pkg.sv
lsu_decode.sv
axil_bridge.sv
load_align.sv
axil_bram.sv
lsu_uncached_top.sv
tb_clkgen.sv
tb_checker.sv
tb_bridge_sva.sv
tb_top.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the uncached LSU regression with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module tb_top -f lsu_uncached.f -o sim_lsu
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_lsu > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" "$log"; then
    exit 1
fi
exit 0

//--- tb_top.sv
// Testbench top: reads the cases file, drives the DUT and prints the totals
module tb_top;
    timeunit 1ns;
    timeprecision 100ps;
    import lsu_pkg::*;

    localparam int wait_limit  = 100;
    localparam int reset_limit = 50;

    logic            clk, rst_n;
    logic [xlen-1:0] address, write_data, read_data;
    logic            read_enable, write_enable;
    logic [2:0]      funct3;
    logic            stall, access_fault;

    // Expectations handed to the checker
    logic            check_en, check_data, exp_fault, exp_stall, saw_stall;
    logic [xlen-1:0] exp_data;
    int              test_num;
    int              pass_count, fail_count, timeout_count, setup_errors, total_fail;

    // File parsing
    string           line;
    int              fd, fields, waited;
    logic [31:0]     op, f3, addr, wdata, expected, fault;

    tb_clkgen u_clkgen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    lsu_uncached_top DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .address      (address),
        .write_data   (write_data),
        .read_enable  (read_enable),
        .write_enable (write_enable),
        .funct3       (funct3),
        .read_data    (read_data),
        .stall        (stall),
        .access_fault (access_fault)
    );

    tb_checker u_checker (
        .clk          (clk),
        .check_en     (check_en),
        .test_num     (test_num),
        .check_data   (check_data),
        .exp_data     (exp_data),
        .exp_fault    (exp_fault),
        .exp_stall    (exp_stall),
        .saw_stall    (saw_stall),
        .read_data    (read_data),
        .access_fault (access_fault),
        .pass_count   (pass_count),
        .fail_count   (fail_count)
    );

    // ============================================================
    // One access: drive, wait for completion, hand off, go idle
    // ============================================================
    task automatic run_case(
        input logic        is_store,
        input logic [2:0]  size_code,
        input logic [31:0] req_addr,
        input logic [31:0] req_data,
        input logic [31:0] load_value,
        input logic        fault_flag
    );
        int   cycles;
        logic finished;
        logic bad_offset;

        cycles     = 0;
        finished   = 1'b0;
        // Odd halfword or unaligned word faults at once, with no stall
        bad_offset = (size_code[1:0] == size_half && req_addr[0]) ||
                     (size_code[1:0] == size_word && req_addr[1:0] != 2'b00);
        test_num   = test_num + 1;

        @(posedge clk);
        address      <= req_addr;
        write_data   <= req_data;
        funct3       <= size_code;
        read_enable  <= !is_store;
        write_enable <= is_store;

        // Stall falls in the retire cycle, request held through it
        while (!finished && cycles < wait_limit) begin
            @(negedge clk);
            if (!stall || access_fault) begin
                finished = 1'b1;
            end else begin
                cycles++;
            end
        end

        if (finished) begin
            check_data = !is_store && !bad_offset;
            exp_data   = load_value;
            exp_fault  = fault_flag;
            exp_stall  = !bad_offset;
            saw_stall  = (cycles != 0);
            check_en   = 1'b1;
        end else begin
            $display("test %0d: timed out, stall still high after %0d cycles",
                     test_num, wait_limit);
            timeout_count++;
        end

        // Strobes low for one cycle so the bridge can retire
        @(posedge clk);
        read_enable  <= 1'b0;
        write_enable <= 1'b0;
        check_en     <= 1'b0;
    endtask

    initial begin
        address       = '0;
        write_data    = '0;
        read_enable   = 1'b0;
        write_enable  = 1'b0;
        funct3        = 3'b000;
        check_en      = 1'b0;
        check_data    = 1'b0;
        exp_data      = '0;
        exp_fault     = 1'b0;
        exp_stall     = 1'b0;
        saw_stall     = 1'b0;
        test_num      = 0;
        timeout_count = 0;
        setup_errors  = 0;

        waited = 0;
        while (!rst_n && waited < reset_limit) begin
            @(posedge clk);
            waited++;
        end

        if (!rst_n) begin
            $display("reset was never released");
            setup_errors++;
        end else begin
            // Test 0 is the idle state right after reset
            @(negedge clk);
            saw_stall = stall;
            check_en  = 1'b1;
            @(posedge clk);
            check_en <= 1'b0;

            fd = $fopen("lsu_cases.txt", "r");
            if (fd == 0) begin
                $display("could not open lsu_cases.txt");
                setup_errors++;
            end else begin
                while (!$feof(fd)) begin
                    if ($fgets(line, fd) != 0) begin
                        // Skip comment lines and anything short of six fields
                        if (line.len() > 0 && line[0] != "#") begin
                            fields = $sscanf(line, "%h %h %h %h %h %h",
                                             op, f3, addr, wdata, expected, fault);
                            if (fields == 6) begin
                                run_case(op[0], f3[2:0], addr, wdata, expected, fault[0]);
                            end
                        end
                    end
                end
                $fclose(fd);
            end
            // Let the checker finish the last comparison
            @(negedge clk);
        end

        total_fail = fail_count + timeout_count + setup_errors;
        $display("Totals: %0d passed, %0d failed", pass_count, total_fail);
        if (total_fail == 0 && pass_count > 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- tb_bridge_sva.sv
// Bridge assertions for exclusive strobes, AR valid hold and the retire cycle after done
module tb_bridge_sva (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    bus_read,
    input logic                    bus_write,
    input logic                    arvalid,
    input logic                    arready,
    input logic                    rvalid,
    input logic                    rready,
    input logic                    bvalid,
    input logic                    bready,
    input logic                    stall,
    input axil_pkg::bridge_state_t state
);
    timeunit 1ns;
    timeprecision 100ps;
    import axil_pkg::*;

    // Never a load and a store in the same request
    read_write_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(bus_read && bus_write))
        else $error("read and write requested in the same cycle");

    // Read address held until the RAM takes it
    arvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid)
        else $error("arvalid dropped before arready");

    // Final beat on either channel, then one cycle with stall low and no restart
    stall_low_after_done: assert property (@(posedge clk) disable iff (!rst_n)
        ((rvalid && rready) || (bvalid && bready)) |=> !stall ##1 state == idle)
        else $error("stall high or bridge restarted in the cycle after done");

endmodule

bind axil_bridge tb_bridge_sva u_bridge_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .bus_read  (bus_read),
    .bus_write (bus_write),
    .arvalid   (arvalid),
    .arready   (arready),
    .rvalid    (rvalid),
    .rready    (rready),
    .bvalid    (bvalid),
    .bready    (bready),
    .stall     (stall),
    .state     (state)
);

//--- tb_checker.sv
// Result checker: compares load data, fault pulse and stall behavior per test
module tb_checker (
    input  logic        clk,
    // Expectations from the testbench top
    input  logic        check_en,
    input  int          test_num,
    input  logic        check_data,
    input  logic [31:0] exp_data,
    input  logic        exp_fault,
    input  logic        exp_stall,
    input  logic        saw_stall,
    // Watched DUT outputs
    input  logic [31:0] read_data,
    input  logic        access_fault,
    output int          pass_count,
    output int          fail_count
);
    timeunit 1ns;
    timeprecision 100ps;

    int errors;

    initial begin
        pass_count = 0;
        fail_count = 0;
    end

    // ============================================================
    // Compare at the edge that closes the completion cycle
    // ============================================================
    always @(posedge clk) begin
        if (check_en) begin
            errors = 0;
            // Data only matters for loads that reached the bus
            if (check_data && read_data !== exp_data) begin
                $display("MISMATCH t=%0t test %0d: read_data %h, expected %h",
                         $time, test_num, read_data, exp_data);
                errors++;
            end
            if (access_fault !== exp_fault) begin
                $display("MISMATCH t=%0t test %0d: access_fault %0b, expected %0b",
                         $time, test_num, access_fault, exp_fault);
                errors++;
            end
            // Misaligned requests must finish without a stall
            if (saw_stall !== exp_stall) begin
                $display("MISMATCH t=%0t test %0d: stall seen %0b, expected %0b",
                         $time, test_num, saw_stall, exp_stall);
                errors++;
            end
            if (errors == 0) begin
                pass_count++;
                $display("test %0d passed: read_data %h fault %0b",
                         test_num, read_data, access_fault);
            end else begin
                fail_count++;
                $display("test %0d failed with %0d wrong values", test_num, errors);
            end
        end
    end

endmodule

//--- tb_clkgen.sv
// Testbench clock and reset generator: 20 ns clock, reset held for 10 cycles
module tb_clkgen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int half_period  = 10;
    localparam int reset_cycles = 10;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // Synchronous active-low reset, released on a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- lsu_uncached_top.sv
// Top level: decode, AXI-Lite bridge, result stage and block RAM
module lsu_uncached_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [lsu_pkg::xlen-1:0] address,
    input  logic [lsu_pkg::xlen-1:0] write_data,
    input  logic                     read_enable,
    input  logic                     write_enable,
    input  logic [2:0]               funct3,
    output logic [lsu_pkg::xlen-1:0] read_data,
    output logic                     stall,
    output logic                     access_fault
);
    import lsu_pkg::*;

    // Decode to bridge
    logic [3:0]      byte_strobe;
    logic [xlen-1:0] lane_data;
    logic            bus_read, bus_write, misaligned;

    // Bridge to result
    logic [xlen-1:0] read_word;

    // ============================================================
    // AXI-Lite bus between bridge and RAM
    // ============================================================
    logic [xlen-1:0] awaddr, wdata, araddr, rdata;
    logic [3:0]      wstrb;
    logic [1:0]      bresp, rresp;
    logic            awvalid, awready, wvalid, wready, bvalid, bready;
    logic            arvalid, arready, rvalid, rready;

    lsu_decode u_decode (
        .address      (address),
        .write_data   (write_data),
        .funct3       (funct3),
        .read_enable  (read_enable),
        .write_enable (write_enable),
        .byte_strobe  (byte_strobe),
        .lane_data    (lane_data),
        .bus_read     (bus_read),
        .bus_write    (bus_write),
        .misaligned   (misaligned)
    );

    axil_bridge u_bridge (
        .clk          (clk),
        .rst_n        (rst_n),
        .address      (address),
        .lane_data    (lane_data),
        .byte_strobe  (byte_strobe),
        .bus_read     (bus_read),
        .bus_write    (bus_write),
        .misaligned   (misaligned),
        .read_word    (read_word),
        .stall        (stall),
        .access_fault (access_fault),
        .awaddr       (awaddr),
        .awvalid      (awvalid),
        .awready      (awready),
        .wdata        (wdata),
        .wstrb        (wstrb),
        .wvalid       (wvalid),
        .wready       (wready),
        .bvalid       (bvalid),
        .bresp        (bresp),
        .bready       (bready),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready),
        .rvalid       (rvalid),
        .rdata        (rdata),
        .rresp        (rresp),
        .rready       (rready)
    );

    // Offset and size come straight from the held request
    load_align u_align (
        .read_word (read_word),
        .offset    (address[1:0]),
        .funct3    (funct3),
        .read_data (read_data)
    );

    axil_bram u_bram (
        .clk     (clk),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bvalid  (bvalid),
        .bresp   (bresp),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rvalid  (rvalid),
        .rdata   (rdata),
        .rresp   (rresp),
        .rready  (rready)
    );

endmodule

//--- axil_bram.sv
// AXI-Lite slave block RAM with byte-strobe writes, one wait cycle and range check
module axil_bram (
    input  logic                     clk,
    input  logic                     rst_n,
    // Write channels
    input  logic [lsu_pkg::xlen-1:0] awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [lsu_pkg::xlen-1:0] wdata,
    input  logic [3:0]               wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    output logic                     bvalid,
    output logic [1:0]               bresp,
    input  logic                     bready,
    // Read channels
    input  logic [lsu_pkg::xlen-1:0] araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output logic                     rvalid,
    output logic [lsu_pkg::xlen-1:0] rdata,
    output logic [1:0]               rresp,
    input  logic                     rready
);
    import lsu_pkg::*;
    import axil_pkg::*;

    logic [xlen-1:0]           mem [mem_words];
    logic [xlen-1:0]           wr_addr;
    logic [mem_index_bits-1:0] wr_index, rd_index;
    logic                      wr_in_range, rd_in_range;

    // Word index and range check for both ports
    assign wr_index    = wr_addr[mem_index_bits+1:2];
    assign rd_index    = araddr[mem_index_bits+1:2];
    assign wr_in_range = wr_addr[xlen-1:2] < mem_words;
    assign rd_in_range = araddr[xlen-1:2] < mem_words;

    initial begin
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = '0;
        end
    end

    // ============================================================
    // Handshake control
    // ============================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            // Ready one cycle after valid, dropped after the beat
            awready <= awvalid && !awready;
            wready  <= wvalid && !wready && !bvalid;
            arready <= arvalid && !arready && !rvalid;
            // Response the cycle after data or address is taken
            if (wvalid && wready) begin
                bvalid <= 1'b1;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (arvalid && arready) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Response payload
    always_ff @(posedge clk) begin
        if (awvalid && awready) begin
            wr_addr <= awaddr;
        end
        if (wvalid && wready) begin
            bresp <= wr_in_range ? resp_okay : resp_slverr;
        end
        if (arvalid && arready) begin
            // Out of range reads return zero
            rdata <= rd_in_range ? mem[rd_index] : '0;
            rresp <= rd_in_range ? resp_okay : resp_slverr;
        end
    end

    // Byte merge under wstrb, nothing written out of range
    always @(posedge clk) begin
        if (wvalid && wready && wr_in_range) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) begin
                    mem[wr_index][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

//--- load_align.sv
// Result stage: lane select and sign or zero extension of the read word
module load_align (
    input  logic [lsu_pkg::xlen-1:0] read_word,
    input  logic [1:0]               offset,
    input  logic [2:0]               funct3,
    output logic [lsu_pkg::xlen-1:0] read_data
);
    import lsu_pkg::*;

    logic [xlen-1:0] shifted;
    logic            sign_fill;

    // Addressed byte or halfword moved down to bit 0
    assign shifted   = read_word >> {offset, 3'b000};
    // LB and LH sign extend, LBU and LHU zero extend
    assign sign_fill = !funct3[load_unsigned];

    always_comb begin
        case (funct3[1:0])
            size_byte: begin
                read_data = {{(xlen - 8){sign_fill & shifted[7]}}, shifted[7:0]};
            end
            size_half: begin
                // Offset 2 lands the upper half here
                read_data = {{(xlen - 16){sign_fill & shifted[15]}}, shifted[15:0]};
            end
            default: begin
                read_data = read_word;
            end
        endcase
    end

endmodule

//--- axil_bridge.sv
// Execute stage: uncached AXI-Lite master FSM with stall, done flag and fault pulse
module axil_bridge (
    input  logic                     clk,
    input  logic                     rst_n,
    // Decoded CPU request
    input  logic [lsu_pkg::xlen-1:0] address,
    input  logic [lsu_pkg::xlen-1:0] lane_data,
    input  logic [3:0]               byte_strobe,
    input  logic                     bus_read,
    input  logic                     bus_write,
    input  logic                     misaligned,
    // Back to the CPU
    output logic [lsu_pkg::xlen-1:0] read_word,
    output logic                     stall,
    output logic                     access_fault,
    // AXI-Lite write channels
    output logic [lsu_pkg::xlen-1:0] awaddr,
    output logic                     awvalid,
    input  logic                     awready,
    output logic [lsu_pkg::xlen-1:0] wdata,
    output logic [3:0]               wstrb,
    output logic                     wvalid,
    input  logic                     wready,
    input  logic                     bvalid,
    input  logic [1:0]               bresp,
    output logic                     bready,
    // AXI-Lite read channels
    output logic [lsu_pkg::xlen-1:0] araddr,
    output logic                     arvalid,
    input  logic                     arready,
    input  logic                     rvalid,
    input  logic [lsu_pkg::xlen-1:0] rdata,
    input  logic [1:0]               rresp,
    output logic                     rready
);
    import axil_pkg::*;

    bridge_state_t state, next_state;

    // Done flag is high for the single cycle after the last beat
    logic tx_done;
    logic comb_stall, seq_stall;
    logic resp_fault;
    logic final_beat, final_bad;

    // ============================================================
    // Next state
    // ============================================================
    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                // No restart while the CPU retires the previous access
                if (!tx_done) begin
                    if (bus_read) begin
                        next_state = send_read_addr;
                    end else if (bus_write) begin
                        next_state = send_write_addr;
                    end
                end
            end
            send_read_addr:  if (arready) next_state = recv_read_data;
            recv_read_data:  if (rvalid)  next_state = idle;
            send_write_addr: if (awready) next_state = send_write_data;
            send_write_data: if (wready)  next_state = wait_write_resp;
            wait_write_resp: if (bvalid)  next_state = idle;
            default:         next_state = idle;
        endcase
    end

    // Last beat of either transaction, and whether it came back bad
    assign final_beat = (state == recv_read_data && rvalid) ||
                        (state == wait_write_resp && bvalid);
    assign final_bad  = (state == recv_read_data && rvalid && rresp != resp_okay) ||
                        (state == wait_write_resp && bvalid && bresp != resp_okay);

    // ============================================================
    // Stall and fault
    // ============================================================
    // Raised combinationally on entry, held by the registered copy
    assign comb_stall   = (next_state != idle) && (bus_read || bus_write);
    assign stall        = (comb_stall || seq_stall) && !tx_done;
    // Misaligned faults immediately, bus errors line up with done
    assign access_fault = resp_fault || misaligned;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= idle;
            seq_stall  <= 1'b0;
            tx_done    <= 1'b0;
            resp_fault <= 1'b0;
            read_word  <= '0;
        end else begin
            state      <= next_state;
            seq_stall  <= comb_stall;
            tx_done    <= final_beat;
            resp_fault <= final_bad;
            // Capture on the read-data beat
            if (rvalid && rready) begin
                read_word <= rdata;
            end
        end
    end

    // ============================================================
    // AXI-Lite master outputs
    // ============================================================
    // Address and data follow the held CPU request
    assign awaddr  = address;
    assign araddr  = address;
    assign wdata   = lane_data;
    assign wstrb   = byte_strobe;

    // One channel active per state, write phases in sequence
    assign awvalid = (state == send_write_addr);
    assign wvalid  = (state == send_write_data);
    assign bready  = (state == wait_write_resp);
    assign arvalid = (state == send_read_addr);
    assign rready  = (state == recv_read_data);

endmodule

//--- lsu_decode.sv
// Decode stage: byte strobes, lane-replicated store data and misalignment flag
module lsu_decode (
    input  logic [lsu_pkg::xlen-1:0] address,
    input  logic [lsu_pkg::xlen-1:0] write_data,
    input  logic [2:0]               funct3,
    input  logic                     read_enable,
    input  logic                     write_enable,
    output logic [3:0]               byte_strobe,
    output logic [lsu_pkg::xlen-1:0] lane_data,
    output logic                     bus_read,
    output logic                     bus_write,
    output logic                     misaligned
);
    import lsu_pkg::*;

    logic [1:0] offset;
    logic       offset_bad;

    // Byte offset inside the addressed word
    assign offset = address[1:0];

    always_comb begin
        offset_bad = 1'b0;
        case (funct3[1:0])
            size_byte: begin
                byte_strobe = 4'b0001 << offset;
                // Same byte on every lane, strobes pick the right one
                lane_data   = {4{write_data[7:0]}};
            end
            size_half: begin
                byte_strobe = 4'b0011 << offset;
                lane_data   = {2{write_data[15:0]}};
                // Odd offsets straddle a halfword boundary
                offset_bad  = offset[0];
            end
            size_word: begin
                byte_strobe = 4'b1111;
                lane_data   = write_data;
                offset_bad  = |offset;
            end
            default: begin
                // Reserved size, no bytes enabled
                byte_strobe = 4'b0000;
                lane_data   = write_data;
            end
        endcase
    end

    // Only a real request can be misaligned
    assign misaligned = (read_enable | write_enable) & offset_bad;

    // Strobes to the bridge, gated off on a fault
    assign bus_read  = read_enable & ~misaligned;
    // A store with no enabled byte never reaches the bus
    assign bus_write = write_enable & ~misaligned & |byte_strobe;

endmodule

//--- axil_pkg.sv
// Bus side definitions: bridge FSM states, AXI-Lite response codes, RAM depth
package axil_pkg;

    // Bridge FSM, one AXI-Lite transaction at a time
    typedef enum logic [2:0] {
        idle,
        send_read_addr,
        recv_read_data,
        send_write_addr,
        send_write_data,
        wait_write_resp
    } bridge_state_t;

    // AXI response codes
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    // RAM depth in words and the matching word index width
    localparam int mem_words      = 256;
    localparam int mem_index_bits = $clog2(mem_words);

endpackage

//--- lsu_pkg.sv
// CPU side definitions: data width, access size codes and load sign rule
package lsu_pkg;

    // ============================================================
    // Data path width
    // ============================================================
    // One word of data and address
    localparam int xlen = 32;

    // ============================================================
    // Access size, low two bits of funct3
    // ============================================================
    localparam logic [1:0] size_byte = 2'b00;
    localparam logic [1:0] size_half = 2'b01;
    localparam logic [1:0] size_word = 2'b10;

    // Position of the unsigned flag inside funct3 (LBU, LHU)
    localparam int load_unsigned = 2;

endpackage
